// File: common/video_pkg.sv
`default_nettype none

package video_pkg;

	////////////////////
	// Screen geometry
	////////////////////

	// One screen coordinate, wide enough for 640 columns
	typedef logic [9:0] coord_t;

	// Pixel currently being scanned
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

	// Colour byte, blue in the top bits
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	// Visible area
	localparam coord_t SCREEN_W = 10'd640;
	localparam coord_t SCREEN_H = 10'd480;

	////////////////////
	// Colours
	////////////////////

	localparam rgb_t COLOR_BLACK = 8'b00000000;
	localparam rgb_t COLOR_WHITE = 8'b11111111;
	localparam rgb_t COLOR_GREEN = 8'b00111000;
	localparam rgb_t COLOR_BLUE  = 8'b11000000;
	localparam rgb_t COLOR_SHIP  = 8'b01111000;
	localparam rgb_t COLOR_ALIEN = 8'b10101010;
	// Yellow shot
	localparam rgb_t COLOR_LASER = 8'b00111111;

	// Border rows of the game screen
	localparam coord_t SCOREBOARD_BOTTOM = 10'd60;
	localparam coord_t BARRIER_BOTTOM    = 10'd400;
	localparam coord_t LIVES_TOP         = 10'd445;

	// Title band rows on the start screen, bottom row excluded
	localparam coord_t TITLE_TOP    = 10'd100;
	localparam coord_t TITLE_BOTTOM = 10'd140;

endpackage

`default_nettype wire

// File: common/game_pkg.sv
`default_nettype none

package game_pkg;

	////////////////////
	// Modes and layers
	////////////////////

	// Display mode, cycled by the display strobe
	typedef enum logic [1:0] {
		MODE_BLACK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME  = 2'd2
	} mode_e;

	// Top-left corner of a moving object
	typedef struct packed {
		video_pkg::coord_t x;
		video_pkg::coord_t y;
	} pos_t;

	// One request on the pixel bus
	typedef struct packed {
		logic            hit;
		video_pkg::rgb_t color;
	} layer_t;

	////////////////////
	// Alien formation
	////////////////////

	localparam int unsigned ALIEN_COLS = 6;
	localparam int unsigned ALIEN_ROWS = 2;

	localparam video_pkg::coord_t ALIEN_W       = 10'd30;
	localparam video_pkg::coord_t ALIEN_H       = 10'd20;
	localparam video_pkg::coord_t ALIEN_PITCH_X = 10'd50;
	localparam video_pkg::coord_t ALIEN_PITCH_Y = 10'd30;

	// Formation corner after reset
	localparam pos_t FLEET_ORIGIN = '{x: 10'd195, y: 10'd150};

	// March rules
	localparam video_pkg::coord_t MARCH_STEP        = 10'd10;
	localparam video_pkg::coord_t DROP_STEP         = 10'd10;
	localparam video_pkg::coord_t FLEET_RIGHT_LIMIT = 10'd620;

	////////////////////
	// Player cannon
	////////////////////

	localparam video_pkg::coord_t SHIP_W       = 10'd40;
	localparam video_pkg::coord_t SHIP_H       = 10'd16;
	localparam video_pkg::coord_t SHIP_Y       = 10'd420;
	localparam video_pkg::coord_t SHIP_START_X = 10'd300;
	localparam video_pkg::coord_t SHIP_STEP    = 10'd8;

	localparam video_pkg::coord_t LASER_W    = 10'd3;
	localparam video_pkg::coord_t LASER_H    = 10'd10;
	localparam video_pkg::coord_t LASER_STEP = 10'd12;

endpackage

`default_nettype wire

// File: rtl/screen_mode.sv
`timescale 1ns/1ps
`default_nettype none

module screen_mode (
	input  wire             clk,
	input  wire             rst,
	input  wire             display_strobe,
	output game_pkg::mode_e mode,
	output logic            game_active
);

	// Black, start, game, then back to black
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode <= game_pkg::MODE_BLACK;
		end else if (display_strobe) begin
			case (mode)
				game_pkg::MODE_BLACK: mode <= game_pkg::MODE_START;
				game_pkg::MODE_START: mode <= game_pkg::MODE_GAME;
				default:              mode <= game_pkg::MODE_BLACK;
			endcase
		end
	end

	// Motion blocks run only on the game screen
	assign game_active = (mode == game_pkg::MODE_GAME);

	// Encoding 3 is never reached
	a_mode_legal : assert property (
		@(posedge clk) disable iff (rst)
		mode inside {game_pkg::MODE_BLACK, game_pkg::MODE_START, game_pkg::MODE_GAME}
	);

endmodule

`default_nettype wire

// File: alien_fleet/alien_march.sv
`timescale 1ns/1ps
`default_nettype none

module alien_march (
	input  wire            clk,
	input  wire            rst,
	input  wire            game_active,
	input  wire            frame_tick,
	output game_pkg::pos_t fleet_pos
);

	// High while marching left
	logic        dir_left;
	// Right edge of the formation after one more step right
	logic [10:0] right_edge_next;
	logic        at_limit;

	////////////////////
	// Side limits
	////////////////////

	// Formation spans five pitches plus one alien
	assign right_edge_next = {1'b0, fleet_pos.x} + {1'b0, game_pkg::MARCH_STEP} +
	                         11'((game_pkg::ALIEN_COLS - 1) * game_pkg::ALIEN_PITCH_X) +
	                         {1'b0, game_pkg::ALIEN_W};

	// Step would cross a side
	always_comb begin
		if (dir_left) begin
			at_limit = (fleet_pos.x < game_pkg::MARCH_STEP);
		end else begin
			at_limit = (right_edge_next > {1'b0, game_pkg::FLEET_RIGHT_LIMIT});
		end
	end

	////////////////////
	// March state
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fleet_pos <= game_pkg::FLEET_ORIGIN;
			dir_left  <= 1'b0;
		end else if (!game_active) begin
			// Fresh formation for the next game
			fleet_pos <= game_pkg::FLEET_ORIGIN;
			dir_left  <= 1'b0;
		end else if (frame_tick) begin
			if (at_limit) begin
				// Drop one step and turn around
				fleet_pos.y <= fleet_pos.y + game_pkg::DROP_STEP;
				dir_left    <= !dir_left;
			end else if (dir_left) begin
				fleet_pos.x <= fleet_pos.x - game_pkg::MARCH_STEP;
			end else begin
				fleet_pos.x <= fleet_pos.x + game_pkg::MARCH_STEP;
			end
		end
	end

	// Horizontal moves happen only on frame ticks during a game
	a_x_on_tick : assert property (
		@(posedge clk) disable iff (rst)
		(game_active && !frame_tick) |=> $stable(fleet_pos.x)
	);

endmodule

`default_nettype wire

// File: alien_fleet/alien_grid.sv
`timescale 1ns/1ps
`default_nettype none

module alien_grid (
	input  wire video_pkg::pixel_t pixel,
	input  wire game_pkg::pos_t    fleet_pos,
	output game_pkg::layer_t       alien_layer
);

	// Pixel falls in column c span or row r span
	logic [game_pkg::ALIEN_COLS-1:0] col_hit;
	logic [game_pkg::ALIEN_ROWS-1:0] row_hit;
	logic [10:0]                     px;
	logic [10:0]                     py;

	// Extra bit keeps box edges from wrapping
	assign px = {1'b0, pixel.x};
	assign py = {1'b0, pixel.y};

	////////////////////
	// Column spans
	////////////////////

	for (genvar c = 0; c < game_pkg::ALIEN_COLS; c++) begin : g_col
		logic [10:0] left;
		assign left = {1'b0, fleet_pos.x} + 11'(c * game_pkg::ALIEN_PITCH_X);
		assign col_hit[c] = (px >= left) && (px < left + {1'b0, game_pkg::ALIEN_W});
	end

	////////////////////
	// Row spans
	////////////////////

	for (genvar r = 0; r < game_pkg::ALIEN_ROWS; r++) begin : g_row
		logic [10:0] top;
		assign top = {1'b0, fleet_pos.y} + 11'(r * game_pkg::ALIEN_PITCH_Y);
		assign row_hit[r] = (py >= top) && (py < top + {1'b0, game_pkg::ALIEN_H});
	end

	// Full rectangular grid, all aliens alive
	assign alien_layer.hit   = (|col_hit) && (|row_hit);
	assign alien_layer.color = video_pkg::COLOR_ALIEN;

endmodule

`default_nettype wire

// File: spaceship/cannon.sv
`timescale 1ns/1ps
`default_nettype none

module cannon (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    game_active,
	input  wire                    frame_tick,
	input  wire                    button_left,
	input  wire                    button_right,
	input  wire                    button_shoot,
	input  wire video_pkg::pixel_t pixel,
	output game_pkg::layer_t       ship_layer,
	output game_pkg::layer_t       laser_layer
);

	video_pkg::coord_t ship_x;
	game_pkg::pos_t    laser_pos;
	logic              laser_active;
	// Next ship x, clamped to the screen
	video_pkg::coord_t ship_x_next;
	logic [10:0]       right_try;
	logic [10:0]       px;
	logic [10:0]       py;

	////////////////////
	// Ship motion
	////////////////////

	assign right_try = {1'b0, ship_x} + {1'b0, game_pkg::SHIP_STEP};

	always_comb begin
		ship_x_next = ship_x;
		if (button_left && !button_right) begin
			// Stop at the left edge
			ship_x_next = (ship_x < game_pkg::SHIP_STEP) ? '0 : ship_x - game_pkg::SHIP_STEP;
		end else if (button_right && !button_left) begin
			if (right_try > {1'b0, video_pkg::SCREEN_W - game_pkg::SHIP_W}) begin
				ship_x_next = video_pkg::SCREEN_W - game_pkg::SHIP_W;
			end else begin
				ship_x_next = right_try[9:0];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x       <= game_pkg::SHIP_START_X;
			laser_active <= 1'b0;
		end else if (!game_active) begin
			// Back to the start position outside the game
			ship_x       <= game_pkg::SHIP_START_X;
			laser_active <= 1'b0;
		end else if (frame_tick) begin
			ship_x <= ship_x_next;
			if (!laser_active) begin
				laser_active <= button_shoot;
			end else if (laser_pos.y < game_pkg::LASER_STEP) begin
				// Gone past the top
				laser_active <= 1'b0;
			end
		end
	end

	// Shot position, only meaningful while active
	always_ff @(posedge clk) begin
		if (frame_tick) begin
			if (!laser_active) begin
				// Launch from the ship nose
				laser_pos.x <= ship_x + (game_pkg::SHIP_W >> 1);
				laser_pos.y <= game_pkg::SHIP_Y - game_pkg::LASER_H;
			end else begin
				laser_pos.y <= laser_pos.y - game_pkg::LASER_STEP;
			end
		end
	end

	////////////////////
	// Pixel hit tests
	////////////////////

	assign px = {1'b0, pixel.x};
	assign py = {1'b0, pixel.y};

	assign ship_layer.hit = (px >= {1'b0, ship_x}) &&
	                        (px < {1'b0, ship_x} + {1'b0, game_pkg::SHIP_W}) &&
	                        (py >= {1'b0, game_pkg::SHIP_Y}) &&
	                        (py < {1'b0, game_pkg::SHIP_Y} + {1'b0, game_pkg::SHIP_H});
	assign ship_layer.color = video_pkg::COLOR_SHIP;

	assign laser_layer.hit = laser_active &&
	                         (px >= {1'b0, laser_pos.x}) &&
	                         (px < {1'b0, laser_pos.x} + {1'b0, game_pkg::LASER_W}) &&
	                         (py >= {1'b0, laser_pos.y}) &&
	                         (py < {1'b0, laser_pos.y} + {1'b0, game_pkg::LASER_H});
	assign laser_layer.color = video_pkg::COLOR_LASER;

	// Ship never leaves the screen
	a_ship_range : assert property (
		@(posedge clk) disable iff (rst)
		ship_x <= video_pkg::SCREEN_W - game_pkg::SHIP_W
	);

endmodule

`default_nettype wire

// File: rtl/layer_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module layer_arbiter (
	input  wire                    clk,
	input  wire                    rst,
	input  wire video_pkg::pixel_t pixel,
	input  wire game_pkg::mode_e   mode,
	input  wire game_pkg::layer_t  ship_layer,
	input  wire game_pkg::layer_t  laser_layer,
	input  wire game_pkg::layer_t  alien_layer,
	output video_pkg::rgb_t        rgb
);

	video_pkg::rgb_t next_rgb;
	logic            on_screen;
	logic            in_title;
	logic            green_row;
	logic            blue_row;

	// Pixel classification
	assign on_screen = (pixel.x < video_pkg::SCREEN_W) && (pixel.y < video_pkg::SCREEN_H);
	assign in_title  = (pixel.y >= video_pkg::TITLE_TOP) && (pixel.y < video_pkg::TITLE_BOTTOM);
	// Scoreboard and lives separators
	assign green_row = (pixel.y == video_pkg::SCOREBOARD_BOTTOM) ||
	                   (pixel.y == video_pkg::LIVES_TOP);
	// Barrier floor
	assign blue_row  = (pixel.y == video_pkg::BARRIER_BOTTOM);

	////////////////////
	// Priority select
	////////////////////

	always_comb begin
		next_rgb = video_pkg::COLOR_BLACK;
		if (on_screen) begin
			case (mode)
				game_pkg::MODE_START: begin
					if (in_title) begin
						next_rgb = video_pkg::COLOR_WHITE;
					end
				end
				game_pkg::MODE_GAME: begin
					// Borders first, then ship, laser, aliens
					if (green_row) begin
						next_rgb = video_pkg::COLOR_GREEN;
					end else if (blue_row) begin
						next_rgb = video_pkg::COLOR_BLUE;
					end else if (ship_layer.hit) begin
						next_rgb = ship_layer.color;
					end else if (laser_layer.hit) begin
						next_rgb = laser_layer.color;
					end else if (alien_layer.hit) begin
						next_rgb = alien_layer.color;
					end
				end
				// Blank screen
				default: next_rgb = video_pkg::COLOR_BLACK;
			endcase
		end
	end

	// Output register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= video_pkg::COLOR_BLACK;
		end else begin
			rgb <= next_rgb;
		end
	end

endmodule

`default_nettype wire

// File: rtl/invaders_top.sv
`timescale 1ns/1ps
`default_nettype none

module invaders_top (
	input  wire                clk,
	input  wire                rst,
	input  wire video_pkg::pixel_t pixel,
	input  wire                frame_tick,
	input  wire                display_strobe,
	input  wire                button_left,
	input  wire                button_right,
	input  wire                button_shoot,
	output video_pkg::rgb_t    rgb
);

	// Mode control
	game_pkg::mode_e mode;
	logic            game_active;

	// Object state and pixel bus requests
	game_pkg::pos_t   fleet_pos;
	game_pkg::layer_t alien_layer;
	game_pkg::layer_t ship_layer;
	game_pkg::layer_t laser_layer;

	screen_mode i_screen_mode (
		.clk            (clk),
		.rst            (rst),
		.display_strobe (display_strobe),
		.mode           (mode),
		.game_active    (game_active)
	);

	////////////////////
	// Alien formation
	////////////////////

	alien_march i_alien_march (
		.clk         (clk),
		.rst         (rst),
		.game_active (game_active),
		.frame_tick  (frame_tick),
		.fleet_pos   (fleet_pos)
	);

	alien_grid i_alien_grid (
		.pixel       (pixel),
		.fleet_pos   (fleet_pos),
		.alien_layer (alien_layer)
	);

	// Ship and its single shot
	cannon i_cannon (
		.clk          (clk),
		.rst          (rst),
		.game_active  (game_active),
		.frame_tick   (frame_tick),
		.button_left  (button_left),
		.button_right (button_right),
		.button_shoot (button_shoot),
		.pixel        (pixel),
		.ship_layer   (ship_layer),
		.laser_layer  (laser_layer)
	);

	// Final colour, one cycle after the pixel
	layer_arbiter i_layer_arbiter (
		.clk         (clk),
		.rst         (rst),
		.pixel       (pixel),
		.mode        (mode),
		.ship_layer  (ship_layer),
		.laser_layer (laser_layer),
		.alien_layer (alien_layer),
		.rgb         (rgb)
	);

endmodule

`default_nettype wire

// File: verification/invaders_model.svh
`ifndef INVADERS_MODEL_SVH
`define INVADERS_MODEL_SVH

////////////////////
// Mirrored game state
////////////////////

game_pkg::mode_e model_mode;
int fleet_x;
int fleet_y;
// Formation heading left
bit fleet_left;
int ship_x;
bit laser_on;
int laser_x;
int laser_y;

// Whole formation, first alien corner to far corner of the last one
localparam int FLEET_W = int'((game_pkg::ALIEN_COLS - 1) * game_pkg::ALIEN_PITCH_X) +
                         int'(game_pkg::ALIEN_W);
localparam int FLEET_H = int'(game_pkg::ALIEN_PITCH_Y) + int'(game_pkg::ALIEN_H);

// Fresh game, as after reset
function automatic void restart_game();
	fleet_x    = int'(game_pkg::FLEET_ORIGIN.x);
	fleet_y    = int'(game_pkg::FLEET_ORIGIN.y);
	fleet_left = 1'b0;
	ship_x     = int'(game_pkg::SHIP_START_X);
	laser_on   = 1'b0;
endfunction

function automatic void reset_model();
	model_mode = game_pkg::MODE_BLACK;
	restart_game();
endfunction

// Step sideways, or drop and turn at a side
function automatic void march_fleet();
	int step;
	bit blocked;
	step = int'(game_pkg::MARCH_STEP);
	if (fleet_left) begin
		blocked = (fleet_x - step < 0);
	end else begin
		blocked = (fleet_x + step + FLEET_W > int'(game_pkg::FLEET_RIGHT_LIMIT));
	end
	if (blocked) begin
		fleet_y    = fleet_y + int'(game_pkg::DROP_STEP);
		fleet_left = !fleet_left;
	end else begin
		fleet_x = fleet_left ? fleet_x - step : fleet_x + step;
	end
endfunction

// Launch uses the ship position before this tick's move
function automatic void move_laser(input bit shoot);
	if (!laser_on) begin
		if (shoot) begin
			laser_on = 1'b1;
			laser_x  = ship_x + int'(game_pkg::SHIP_W) / 2;
			laser_y  = int'(game_pkg::SHIP_Y) - int'(game_pkg::LASER_H);
		end
	end else if (laser_y < int'(game_pkg::LASER_STEP)) begin
		laser_on = 1'b0;
	end else begin
		laser_y = laser_y - int'(game_pkg::LASER_STEP);
	end
endfunction

function automatic void move_ship(input bit left, input bit right);
	int step;
	int max_x;
	step  = int'(game_pkg::SHIP_STEP);
	max_x = int'(video_pkg::SCREEN_W) - int'(game_pkg::SHIP_W);
	if (left && !right) begin
		ship_x = (ship_x < step) ? 0 : ship_x - step;
	end else if (right && !left) begin
		ship_x = (ship_x + step > max_x) ? max_x : ship_x + step;
	end
endfunction

// One rising edge; motion sees the mode held before the edge
function automatic void step_model(input bit tick, input bit strobe, input bit left,
		input bit right, input bit shoot);
	if (model_mode != game_pkg::MODE_GAME) begin
		restart_game();
	end else if (tick) begin
		march_fleet();
		move_laser(shoot);
		move_ship(left, right);
	end
	if (strobe) begin
		case (model_mode)
			game_pkg::MODE_BLACK: model_mode = game_pkg::MODE_START;
			game_pkg::MODE_START: model_mode = game_pkg::MODE_GAME;
			default:              model_mode = game_pkg::MODE_BLACK;
		endcase
	end
endfunction

function automatic bit in_box(input int px, input int py, input int x, input int y,
		input int w, input int h);
	return (px >= x) && (px < x + w) && (py >= y) && (py < y + h);
endfunction

////////////////////
// Expected colour
////////////////////

function automatic video_pkg::rgb_t expected_color(input video_pkg::pixel_t p);
	int px;
	int py;
	bit alien;
	px    = int'(p.x);
	py    = int'(p.y);
	alien = 1'b0;
	for (int r = 0; r < int'(game_pkg::ALIEN_ROWS); r++) begin
		for (int c = 0; c < int'(game_pkg::ALIEN_COLS); c++) begin
			alien |= in_box(px, py, fleet_x + c * int'(game_pkg::ALIEN_PITCH_X),
			                fleet_y + r * int'(game_pkg::ALIEN_PITCH_Y),
			                int'(game_pkg::ALIEN_W), int'(game_pkg::ALIEN_H));
		end
	end
	// Outside the visible area
	if (px >= int'(video_pkg::SCREEN_W) || py >= int'(video_pkg::SCREEN_H)) begin
		return video_pkg::COLOR_BLACK;
	end
	if (model_mode == game_pkg::MODE_START) begin
		if (py >= int'(video_pkg::TITLE_TOP) && py < int'(video_pkg::TITLE_BOTTOM)) begin
			return video_pkg::COLOR_WHITE;
		end
		return video_pkg::COLOR_BLACK;
	end
	if (model_mode != game_pkg::MODE_GAME) begin
		return video_pkg::COLOR_BLACK;
	end
	// Borders, ship, laser, aliens
	if (py == int'(video_pkg::SCOREBOARD_BOTTOM) || py == int'(video_pkg::LIVES_TOP)) begin
		return video_pkg::COLOR_GREEN;
	end
	if (py == int'(video_pkg::BARRIER_BOTTOM)) begin
		return video_pkg::COLOR_BLUE;
	end
	if (in_box(px, py, ship_x, int'(game_pkg::SHIP_Y), int'(game_pkg::SHIP_W),
	           int'(game_pkg::SHIP_H))) begin
		return video_pkg::COLOR_SHIP;
	end
	if (laser_on && in_box(px, py, laser_x, laser_y, int'(game_pkg::LASER_W),
	                       int'(game_pkg::LASER_H))) begin
		return video_pkg::COLOR_LASER;
	end
	if (alien) begin
		return video_pkg::COLOR_ALIEN;
	end
	return video_pkg::COLOR_BLACK;
endfunction

`endif

// File: verification/invaders_tb.sv
`timescale 1ns/1ps
`default_nettype none

module invaders_tb;

	localparam int CLK_PERIOD = 4;
	// Upper bound of each test in cycles, summed
	localparam int TEST_CYCLES = 250 + 600 + 6200 + 700 + 3900 + 600;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 10) * CLK_PERIOD + 2000;

	logic              clk;
	logic              rst;
	video_pkg::pixel_t pixel;
	logic              frame_tick;
	logic              display_strobe;
	logic              button_left;
	logic              button_right;
	logic              button_shoot;
	video_pkg::rgb_t   rgb;

	integer seed = 31;
	int     errors = 0;
	int     checks = 0;
	int     tests_done = 0;
	int     test_start_errors = 0;

	// Expectation for the pixel sampled at the last rising edge
	video_pkg::rgb_t   exp_rgb;
	video_pkg::pixel_t exp_pixel;
	bit                exp_valid = 1'b0;

	`include "invaders_model.svh"

	invaders_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.pixel          (pixel),
		.frame_tick     (frame_tick),
		.display_strobe (display_strobe),
		.button_left    (button_left),
		.button_right   (button_right),
		.button_shoot   (button_shoot),
		.rgb            (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// Model and compare
	////////////////////

	// Colour from the state before the edge, then advance
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			reset_model();
			exp_valid = 1'b0;
		end else begin
			exp_rgb   = expected_color(pixel);
			exp_pixel = pixel;
			exp_valid = 1'b1;
			step_model(frame_tick, display_strobe, button_left, button_right, button_shoot);
		end
	end

	// Registered colour is stable at the falling edge
	always @(negedge clk) begin
		if (exp_valid) begin
			check_rgb(exp_rgb, rgb, exp_pixel);
		end
	end

	task automatic check_rgb(input video_pkg::rgb_t expected, input video_pkg::rgb_t actual,
			input video_pkg::pixel_t p);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t ns: pixel (%0d,%0d) expected %02h got %02h",
			         $time, p.x, p.y, expected, actual);
		end
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic drive_pixel(input int x, input int y, input bit tick = 1'b0,
			input bit strobe = 1'b0);
		@(negedge clk);
		pixel.x        = video_pkg::coord_t'(x);
		pixel.y        = video_pkg::coord_t'(y);
		frame_tick     = tick;
		display_strobe = strobe;
	endtask

	// Full 10-bit range unless held to the screen
	task automatic drive_random(input int n, input bit on_screen, input bit tick);
		int r;
		int x;
		int y;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			x = r & 32'h3ff;
			y = (r >>> 10) & 32'h3ff;
			if (on_screen) begin
				x = x % int'(video_pkg::SCREEN_W);
				y = y % int'(video_pkg::SCREEN_H);
			end
			drive_pixel(x, y, tick);
		end
	endtask

	task automatic drive_offscreen();
		drive_pixel(640, 0);
		drive_pixel(639, 480);
		drive_pixel(700, 120);
		drive_pixel(320, 600);
		drive_pixel(1023, 1023);
		drive_pixel(640, 479);
		drive_pixel(0, 480);
		// Border rows continued past the right side
		drive_pixel(700, 60);
		drive_pixel(660, 400);
	endtask

	task automatic strobe_display();
		drive_pixel(320, 120, 1'b0, 1'b1);
	endtask

	// Two inside corners and two pixels just outside
	task automatic probe_box(input int x, input int y, input int w, input int h);
		drive_pixel(x, y);
		drive_pixel(x + w - 1, y + h - 1);
		drive_pixel(x - 1, y);
		drive_pixel(x + w, y + h - 1);
	endtask

	task automatic probe_fleet();
		for (int r = 0; r < int'(game_pkg::ALIEN_ROWS); r++) begin
			for (int c = 0; c < int'(game_pkg::ALIEN_COLS); c++) begin
				probe_box(fleet_x + c * int'(game_pkg::ALIEN_PITCH_X),
				          fleet_y + r * int'(game_pkg::ALIEN_PITCH_Y),
				          game_pkg::ALIEN_W, game_pkg::ALIEN_H);
			end
		end
	endtask

	task automatic scan_rows(input int y0, input int y1, input int ystep, input int xstep);
		for (int y = y0; y <= y1; y += ystep) begin
			for (int x = 0; x < int'(video_pkg::SCREEN_W); x += xstep) begin
				drive_pixel(x, y);
			end
		end
	endtask

	// Tick, let the state settle, then look at the ship
	task automatic ship_step();
		drive_random(1, 1'b1, 1'b1);
		drive_random(1, 1'b1, 1'b0);
		probe_box(ship_x, game_pkg::SHIP_Y, game_pkg::SHIP_W, game_pkg::SHIP_H);
	endtask

	// Flush the last pixel through the compare
	task automatic finish_test(input string name);
		drive_pixel(0, 0);
		drive_pixel(0, 0);
		// Compares of this falling edge are done by the rising edge
		@(posedge clk);
		tests_done++;
		$display("Test %0d %s done with %0d errors", tests_done, name,
		         errors - test_start_errors);
		test_start_errors = errors;
		@(negedge clk);
	endtask

	////////////////////
	// Tests
	////////////////////

	initial begin
		rst            = 1'b1;
		pixel          = '0;
		frame_tick     = 1'b0;
		display_strobe = 1'b0;
		button_left    = 1'b0;
		button_right   = 1'b0;
		button_shoot   = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Black screen after reset
		drive_random(150, 1'b1, 1'b0);
		drive_random(50, 1'b0, 1'b0);
		drive_offscreen();
		finish_test("reset_black");

		// Start band, then game, then back to black
		strobe_display();
		for (int y = 0; y < int'(video_pkg::SCREEN_H); y++) begin
			drive_pixel((y * 37) % 640, y);
		end
		drive_offscreen();
		strobe_display();
		drive_offscreen();
		strobe_display();
		drive_random(20, 1'b1, 1'b0);
		finish_test("mode_cycle");

		// Fresh game picture
		strobe_display();
		strobe_display();
		scan_rows(58, 62, 1, 8);
		scan_rows(146, 204, 3, 5);
		scan_rows(398, 402, 1, 8);
		scan_rows(418, 438, 2, 4);
		scan_rows(443, 447, 1, 8);
		probe_box(ship_x, game_pkg::SHIP_Y, game_pkg::SHIP_W, game_pkg::SHIP_H);
		probe_fleet();
		drive_random(500, 1'b1, 1'b0);
		drive_offscreen();
		finish_test("fresh_game");

		// Right to the limit, drop, back left
		for (int i = 0; i < 60; i++) begin
			drive_random(1, 1'b1, 1'b1);
			drive_random(1, 1'b1, 1'b0);
			probe_box(fleet_x, fleet_y, FLEET_W, FLEET_H);
			drive_random(4, 1'b1, 1'b0);
		end
		finish_test("fleet_march");

		// Clamp at both edges, both buttons cancel
		button_left = 1'b1;
		repeat (45) ship_step();
		button_left  = 1'b0;
		button_right = 1'b1;
		repeat (80) ship_step();
		button_left = 1'b1;
		repeat (4) ship_step();
		button_right = 1'b0;
		// Walk the fleet down onto the ship rows
		for (int i = 0; (i < 1200) && (fleet_y + FLEET_H < int'(game_pkg::SHIP_Y) + 8); i++) begin
			if (ship_x <= 320) begin
				button_left = 1'b0;
			end
			drive_random(1, 1'b1, 1'b1);
		end
		button_left = 1'b0;
		if (fleet_y + FLEET_H < int'(game_pkg::SHIP_Y) + 8) begin
			errors++;
			$display("Error: the fleet never came down to the ship rows");
		end
		scan_rows(418, 438, 2, 4);
		probe_box(ship_x, game_pkg::SHIP_Y, game_pkg::SHIP_W, game_pkg::SHIP_H);
		finish_test("ship_move");

		// New game, then one shot to the top
		strobe_display();
		strobe_display();
		strobe_display();
		button_shoot = 1'b1;
		drive_random(1, 1'b1, 1'b1);
		drive_random(1, 1'b1, 1'b0);
		button_shoot = 1'b0;
		for (int i = 0; i < 40; i++) begin
			drive_random(1, 1'b1, 1'b0);
			probe_box(laser_x, laser_y, game_pkg::LASER_W, game_pkg::LASER_H);
			drive_random(1, 1'b1, 1'b1);
		end
		// A second shot launches only once the first one is gone
		button_shoot = 1'b1;
		drive_random(1, 1'b1, 1'b1);
		drive_random(1, 1'b1, 1'b0);
		button_shoot = 1'b0;
		probe_box(laser_x, laser_y, game_pkg::LASER_W, game_pkg::LASER_H);
		// Leave the game and come back
		strobe_display();
		drive_random(3, 1'b1, 1'b1);
		strobe_display();
		strobe_display();
		probe_fleet();
		probe_box(ship_x, game_pkg::SHIP_Y, game_pkg::SHIP_W, game_pkg::SHIP_H);
		drive_random(200, 1'b1, 1'b0);
		finish_test("laser_restart");

		// Last compares settle before the counts
		@(posedge clk);
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: invaders.f
+incdir+verification
common/video_pkg.sv
common/game_pkg.sv
rtl/screen_mode.sv
alien_fleet/alien_march.sv
alien_fleet/alien_grid.sv
spaceship/cannon.sv
rtl/layer_arbiter.sv
rtl/invaders_top.sv
verification/invaders_tb.sv

// File: Bender.yml
package:
  name: invaders

sources:
  - common/video_pkg.sv
  - common/game_pkg.sv
  - rtl/screen_mode.sv
  - alien_fleet/alien_march.sv
  - alien_fleet/alien_grid.sv
  - spaceship/cannon.sv
  - rtl/layer_arbiter.sv
  - rtl/invaders_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/invaders_tb.sv
